// ==== verilog/loopPkg.sv ====
`default_nettype none

package loopPkg;

    // Bus and datapath widths.
    localparam int ADDR_WIDTH = 12;
    localparam int DATA_WIDTH = 32;

    // Register map. Each register occupies one 32-bit word.
    localparam logic [ADDR_WIDTH-1:0] LF_CONTROL      = 12'h000;
    localparam logic [ADDR_WIDTH-1:0] LF_LEAD_LAG     = 12'h004;
    localparam logic [ADDR_WIDTH-1:0] LF_LIMIT        = 12'h008;
    localparam logic [ADDR_WIDTH-1:0] LF_LOOPDATA     = 12'h00C;
    localparam logic [ADDR_WIDTH-1:0] LF_LOCKDETECTOR = 12'h010;
    localparam logic [ADDR_WIDTH-1:0] LF_INTEGRATOR   = 12'h014;

    // Gain fields are a mantissa and a right-shift exponent.
    localparam int EXP_WIDTH = 5;
    localparam int MAN_WIDTH = 8;

    localparam int LOCK_COUNT_WIDTH = 16;
    localparam int SYNC_WIDTH       = 12;

    // Cycles from errorStrobe to termStrobe in the scaler.
    localparam int SCALER_LATENCY = 1;

endpackage

`default_nettype wire

// ==== verilog/loopCtrlIf.sv ====
`default_nettype none

interface loopCtrlIf #(
    parameter int ERROR_WIDTH = 16
);

    logic                                    zeroError;
    logic                                    invertError;
    logic                                    clearAccum;
    logic [loopPkg::EXP_WIDTH-1:0]           leadExp;
    logic [loopPkg::MAN_WIDTH-1:0]           leadMan;
    logic [loopPkg::EXP_WIDTH-1:0]           lagExp;
    logic [loopPkg::MAN_WIDTH-1:0]           lagMan;
    logic [loopPkg::DATA_WIDTH-1:0]          limit;
    logic [loopPkg::DATA_WIDTH-1:0]          loopData;
    logic [loopPkg::LOCK_COUNT_WIDTH-1:0]    lockCount;
    logic [loopPkg::SYNC_WIDTH-1:0]          syncThreshold;

    // The scaled product, with one bit of headroom for a negated minimum error,
    // has to fit in the accumulator word.
    if (ERROR_WIDTH + loopPkg::MAN_WIDTH + 2 > loopPkg::DATA_WIDTH) begin : gWidthCheck
        $error("ERROR_WIDTH %0d is too wide for the accumulator", ERROR_WIDTH);
    end

    modport regs (output zeroError, invertError, clearAccum, leadExp, leadMan,
                  lagExp, lagMan, limit, loopData, lockCount, syncThreshold);
    modport scale (input zeroError, invertError, leadExp, leadMan, lagExp, lagMan);
    modport integ (input clearAccum);
    modport comb (input limit, loopData);
    modport lock (input lockCount, syncThreshold);

endinterface

`default_nettype wire

// ==== verilog/loopRegs.sv ====
`default_nettype none

module loopRegs (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic [loopPkg::ADDR_WIDTH-1:0]    addr,
    input  logic [loopPkg::DATA_WIDTH-1:0]    dataIn,
    output logic [loopPkg::DATA_WIDTH-1:0]    dataOut,
    input  logic                              cs,
    input  logic                              wr0,
    input  logic                              wr1,
    input  logic                              wr2,
    input  logic                              wr3,
    input  logic [loopPkg::DATA_WIDTH-1:0]    lagAccum,
    input  logic                              lockStatus,
    loopCtrlIf.regs                           ctrl
);

    logic [3:0] byteEn;

    // Replaces the enabled bytes of a full word.
    function automatic logic [loopPkg::DATA_WIDTH-1:0] mergeBytes(
        input logic [loopPkg::DATA_WIDTH-1:0] oldWord,
        input logic [loopPkg::DATA_WIDTH-1:0] newWord,
        input logic [3:0]                     enables
    );
        logic [loopPkg::DATA_WIDTH-1:0] merged;
        merged = oldWord;
        for (int i = 0; i < 4; i++) begin
            if (enables[i]) begin
                merged[8*i +: 8] = newWord[8*i +: 8];
            end
        end
        return merged;
    endfunction

    assign byteEn = {wr3, wr2, wr1, wr0};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ctrl.zeroError     <= 1'b0;
            ctrl.invertError   <= 1'b0;
            ctrl.clearAccum    <= 1'b0;
            ctrl.leadExp       <= '0;
            ctrl.leadMan       <= '0;
            ctrl.lagExp        <= '0;
            ctrl.lagMan        <= '0;
            ctrl.limit         <= '0;
            ctrl.loopData      <= '0;
            ctrl.lockCount     <= '0;
            ctrl.syncThreshold <= '0;
        end else if (cs) begin
            case (addr)
                loopPkg::LF_CONTROL: begin
                    if (wr0) begin // Control bits live in the low byte only.
                        ctrl.zeroError   <= dataIn[0];
                        ctrl.invertError <= dataIn[1];
                        ctrl.clearAccum  <= dataIn[3];
                    end
                end
                loopPkg::LF_LEAD_LAG: begin
                    if (wr0) ctrl.lagExp <= dataIn[4:0];
                    if (wr1) ctrl.lagMan <= dataIn[15:8];
                    if (wr2) ctrl.leadExp <= dataIn[20:16];
                    if (wr3) ctrl.leadMan <= dataIn[31:24];
                end
                loopPkg::LF_LIMIT:    ctrl.limit <= mergeBytes(ctrl.limit, dataIn, byteEn);
                loopPkg::LF_LOOPDATA: ctrl.loopData <= mergeBytes(ctrl.loopData, dataIn, byteEn);
                loopPkg::LF_LOCKDETECTOR: begin
                    if (wr0) ctrl.lockCount[7:0] <= dataIn[7:0];
                    if (wr1) ctrl.lockCount[15:8] <= dataIn[15:8];
                    if (wr2) ctrl.syncThreshold[7:0] <= dataIn[23:16];
                    if (wr3) ctrl.syncThreshold[11:8] <= dataIn[27:24];
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        dataOut = '0;
        if (cs) begin
            case (addr)
                loopPkg::LF_CONTROL:
                    dataOut = {lockStatus, 27'b0, ctrl.clearAccum, 1'b0,
                               ctrl.invertError, ctrl.zeroError};
                loopPkg::LF_LEAD_LAG:
                    dataOut = {ctrl.leadMan, 3'b0, ctrl.leadExp,
                               ctrl.lagMan, 3'b0, ctrl.lagExp};
                loopPkg::LF_LIMIT:        dataOut = ctrl.limit;
                loopPkg::LF_LOOPDATA:     dataOut = ctrl.loopData;
                loopPkg::LF_LOCKDETECTOR: dataOut = {4'h0, ctrl.syncThreshold, ctrl.lockCount};
                loopPkg::LF_INTEGRATOR:   dataOut = lagAccum; // Live accumulator value.
                default:                  dataOut = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/errorScaler.sv ====
`default_nettype none

module errorScaler #(
    parameter int ERROR_WIDTH = 16
) (
    input  logic                                   clk,
    input  logic                                   rstN,
    input  logic signed [ERROR_WIDTH-1:0]          error,
    input  logic                                   errorStrobe,
    input  logic                                   zeroError,
    input  logic                                   invertError,
    input  logic [loopPkg::EXP_WIDTH-1:0]          gainExp,
    input  logic [loopPkg::MAN_WIDTH-1:0]          gainMan,
    output logic signed [loopPkg::DATA_WIDTH-1:0]  term,
    output logic                                   termStrobe
);

    // One extra bit so that negating the most negative error cannot overflow.
    logic signed [ERROR_WIDTH:0]                      condError;
    logic signed [ERROR_WIDTH+loopPkg::MAN_WIDTH+1:0] product;
    logic signed [loopPkg::DATA_WIDTH-1:0]            wideProduct;

    always_comb begin
        if (zeroError) begin
            condError = '0;
        end else if (invertError) begin
            condError = -{error[ERROR_WIDTH-1], error};
        end else begin
            condError = {error[ERROR_WIDTH-1], error};
        end
    end

    assign product     = condError * $signed({1'b0, gainMan}); // Mantissa is unsigned.
    assign wideProduct = loopPkg::DATA_WIDTH'(product);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            termStrobe <= 1'b0;
        end else begin
            termStrobe <= errorStrobe;
        end
    end

    always_ff @(posedge clk) begin
        term <= wideProduct >>> gainExp;
    end

endmodule

`default_nettype wire

// ==== verilog/lagIntegrator.sv ====
`default_nettype none

module lagIntegrator (
    input  logic                                   clk,
    input  logic                                   rstN,
    input  logic signed [loopPkg::DATA_WIDTH-1:0]  term,
    input  logic                                   termStrobe,
    loopCtrlIf.integ                               ctrl,
    output logic signed [loopPkg::DATA_WIDTH-1:0]  lagAccum,
    output logic                                   accumStrobe
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            lagAccum    <= '0;
            accumStrobe <= 1'b0;
        end else begin
            // The strobe keeps its fixed latency even while the accumulator is held clear.
            accumStrobe <= termStrobe;
            if (ctrl.clearAccum) begin
                lagAccum <= '0;
            end else if (termStrobe) begin
                lagAccum <= lagAccum + term; // Wraps at 32 bits.
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/loopCombiner.sv ====
`default_nettype none

module loopCombiner (
    input  logic                                   clk,
    input  logic                                   rstN,
    input  logic signed [loopPkg::DATA_WIDTH-1:0]  leadTerm,
    input  logic                                   leadStrobe,
    input  logic signed [loopPkg::DATA_WIDTH-1:0]  lagAccum,
    input  logic                                   accumStrobe,
    loopCtrlIf.comb                                ctrl,
    output logic [loopPkg::DATA_WIDTH-1:0]         loopOut,
    output logic                                   loopStrobe
);

    logic signed [loopPkg::DATA_WIDTH-1:0] leadHold;
    logic signed [loopPkg::DATA_WIDTH:0]   sum;
    logic signed [loopPkg::DATA_WIDTH:0]   posLimit;
    logic signed [loopPkg::DATA_WIDTH:0]   negLimit;
    logic signed [loopPkg::DATA_WIDTH:0]   clamped;

    // The lead term lands one cycle before the integrator has taken the same sample.
    always_ff @(posedge clk) begin
        if (leadStrobe) leadHold <= leadTerm;
    end

    assign sum      = {leadHold[loopPkg::DATA_WIDTH-1], leadHold}
                    + {lagAccum[loopPkg::DATA_WIDTH-1], lagAccum};
    assign posLimit = {1'b0, ctrl.limit};
    assign negLimit = -posLimit;

    always_comb begin
        if (sum > posLimit) begin
            clamped = posLimit;
        end else if (sum < negLimit) begin
            clamped = negLimit;
        end else begin
            clamped = sum;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            loopOut    <= '0;
            loopStrobe <= 1'b0;
        end else begin
            loopStrobe <= accumStrobe;
            if (accumStrobe) begin
                loopOut <= ctrl.loopData + clamped[loopPkg::DATA_WIDTH-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lockDetector.sv ====
`default_nettype none

module lockDetector #(
    parameter int ERROR_WIDTH = 16
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic signed [ERROR_WIDTH-1:0] error,
    input  logic                          errorStrobe,
    loopCtrlIf.lock                       ctrl,
    output logic                          lockStatus
);

    localparam int CW = loopPkg::LOCK_COUNT_WIDTH;

    logic [ERROR_WIDTH-1:0] errMag;
    logic [CW-1:0]          count;
    logic [CW-1:0]          nextCount;
    logic [CW-1:0]          target;

    // Unsigned magnitude, so the most negative error is still represented.
    assign errMag = error[ERROR_WIDTH-1] ? ERROR_WIDTH'(-error) : ERROR_WIDTH'(error);

    assign nextCount = (&count) ? count : count + 1'b1; // Saturates.
    assign target    = (ctrl.lockCount == '0) ? CW'(1) : ctrl.lockCount;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            count      <= '0;
            lockStatus <= 1'b0;
        end else if (errorStrobe) begin
            if (errMag <= ctrl.syncThreshold) begin
                count <= nextCount;
                if (nextCount >= target) lockStatus <= 1'b1;
            end else begin
                count      <= '0;
                lockStatus <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/loopFilter.sv ====
`default_nettype none

module loopFilter #(
    parameter int ERROR_WIDTH = 16
) (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic [loopPkg::ADDR_WIDTH-1:0]    addr,
    input  logic [loopPkg::DATA_WIDTH-1:0]    dataIn,
    output logic [loopPkg::DATA_WIDTH-1:0]    dataOut,
    input  logic                              cs,
    input  logic                              wr0,
    input  logic                              wr1,
    input  logic                              wr2,
    input  logic                              wr3,
    input  logic signed [ERROR_WIDTH-1:0]     error,
    input  logic                              errorStrobe,
    output logic [loopPkg::DATA_WIDTH-1:0]    loopOut,
    output logic                              loopStrobe,
    output logic                              lockStatus
);

    logic signed [loopPkg::DATA_WIDTH-1:0] leadTerm;
    logic                                  leadStrobe;
    logic signed [loopPkg::DATA_WIDTH-1:0] lagTerm;
    logic                                  lagStrobe;
    logic signed [loopPkg::DATA_WIDTH-1:0] lagAccum;
    logic                                  accumStrobe;

    loopCtrlIf #(.ERROR_WIDTH(ERROR_WIDTH)) ctrlBus ();

    loopRegs regs (
        .clk, .rstN, .addr, .dataIn, .dataOut, .cs, .wr0, .wr1, .wr2, .wr3,
        .lagAccum, .lockStatus, .ctrl(ctrlBus.regs)
    );

    // Both paths share the conditioning bits and differ only in their gain pair.
    errorScaler #(.ERROR_WIDTH(ERROR_WIDTH)) leadScaler (
        .clk, .rstN, .error, .errorStrobe,
        .zeroError(ctrlBus.zeroError), .invertError(ctrlBus.invertError),
        .gainExp(ctrlBus.leadExp), .gainMan(ctrlBus.leadMan),
        .term(leadTerm), .termStrobe(leadStrobe)
    );

    errorScaler #(.ERROR_WIDTH(ERROR_WIDTH)) lagScaler (
        .clk, .rstN, .error, .errorStrobe,
        .zeroError(ctrlBus.zeroError), .invertError(ctrlBus.invertError),
        .gainExp(ctrlBus.lagExp), .gainMan(ctrlBus.lagMan),
        .term(lagTerm), .termStrobe(lagStrobe)
    );

    lagIntegrator integ (
        .clk, .rstN, .term(lagTerm), .termStrobe(lagStrobe),
        .ctrl(ctrlBus.integ), .lagAccum, .accumStrobe
    );

    loopCombiner comb (
        .clk, .rstN, .leadTerm, .leadStrobe, .lagAccum, .accumStrobe,
        .ctrl(ctrlBus.comb), .loopOut, .loopStrobe
    );

    lockDetector #(.ERROR_WIDTH(ERROR_WIDTH)) lock (
        .clk, .rstN, .error, .errorStrobe, .ctrl(ctrlBus.lock), .lockStatus
    );

endmodule

`default_nettype wire

// ==== verification/loopFilter_assertions.sv ====
`default_nettype none

module loopFilterAssertions #(
    parameter int ERROR_WIDTH = 16
) (
    input wire logic                                clk,
    input wire logic                                rstN,
    input wire logic signed [ERROR_WIDTH-1:0]       error,
    input wire logic                                errorStrobe,
    input wire logic                                loopStrobe,
    input wire logic                                lockStatus,
    input wire logic [loopPkg::SYNC_WIDTH-1:0]      syncThreshold
);
    timeunit 1ns;
    timeprecision 10ps;

    localparam int PIPE_DEPTH = loopPkg::SCALER_LATENCY + 2; // Scaler, integrator, combiner.

    logic [ERROR_WIDTH-1:0] errMag;

    assign errMag = error[ERROR_WIDTH-1] ? ERROR_WIDTH'(-error) : ERROR_WIDTH'(error);

    strobeFollows: assert property (@(posedge clk) disable iff (!rstN)
        errorStrobe |-> ##PIPE_DEPTH loopStrobe)
        else $error("loopStrobe missing %0d cycles after errorStrobe", PIPE_DEPTH);

    strobeHasSource: assert property (@(posedge clk) disable iff (!rstN)
        loopStrobe |-> $past(errorStrobe, PIPE_DEPTH))
        else $error("loopStrobe without a matching errorStrobe");

    quietAfterReset: assert property (@(posedge clk)
        $rose(rstN) |-> (!loopStrobe && !lockStatus))
        else $error("loopStrobe or lockStatus high on the first cycle after reset");

    // A single large error always breaks lock.
    lockDropsOnLargeError: assert property (@(posedge clk) disable iff (!rstN)
        (errorStrobe && (errMag > syncThreshold)) |=> !lockStatus)
        else $error("lockStatus still set after a large error");

endmodule

bind loopFilter loopFilterAssertions #(.ERROR_WIDTH(ERROR_WIDTH)) checks (
    .clk(clk),
    .rstN(rstN),
    .error(error),
    .errorStrobe(errorStrobe),
    .loopStrobe(loopStrobe),
    .lockStatus(lockStatus),
    .syncThreshold(ctrlBus.syncThreshold)
);

`default_nettype wire

// ==== verification/tbLoopFilter.sv ====
`default_nettype none

module tbLoopFilter;
    timeunit 1ns;
    timeprecision 10ps;

    localparam int ERROR_WIDTH = 16;
    localparam int OUT_TIMEOUT = 20; // Cycles allowed for all samples in flight to drain.

    logic                                 clk;
    logic                                 rstN;
    logic [loopPkg::ADDR_WIDTH-1:0]       addr;
    logic [loopPkg::DATA_WIDTH-1:0]       dataIn;
    logic [loopPkg::DATA_WIDTH-1:0]       dataOut;
    logic                                 cs;
    logic [3:0]                           wrEn;
    logic signed [ERROR_WIDTH-1:0]        error;
    logic                                 errorStrobe;
    logic [loopPkg::DATA_WIDTH-1:0]       loopOut;
    logic                                 loopStrobe;
    logic                                 lockStatus;

    // Software copies of the register settings and the integrator.
    logic        regZero, regInv, regClear;
    logic [7:0]  regLeadMan, regLagMan;
    logic [4:0]  regLeadExp, regLagExp;
    logic [31:0] regLimit, regLoopData;
    logic [31:0] modelAccum;

    logic [31:0] expQ[$];
    int          sendQ[$];
    int          cycleCount;
    logic [31:0] lastOut;
    logic [31:0] rdData;

    loopFilter #(.ERROR_WIDTH(ERROR_WIDTH)) dut (
        .clk, .rstN, .addr, .dataIn, .dataOut, .cs,
        .wr0(wrEn[0]), .wr1(wrEn[1]), .wr2(wrEn[2]), .wr3(wrEn[3]),
        .error, .errorStrobe, .loopOut, .loopStrobe, .lockStatus
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycleCount <= cycleCount + 1;

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    // Outputs are compared at the falling edge where no input changes.
    always @(negedge clk) begin
        if (rstN && loopStrobe) begin
            if (expQ.size() == 0) begin
                $display("Unexpected loopStrobe at %0t ns with no sample in flight", $time);
                $display("Finished with errors");
                $fatal(1);
            end else begin
                checkValue("loopStrobe latency", cycleCount - sendQ.pop_front(), 3);
                checkValue("loopOut", loopOut, expQ.pop_front());
                lastOut = loopOut;
            end
        end
    end

    task automatic stepCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic writeReg(input logic [11:0] a, input logic [31:0] d, input logic [3:0] strb);
        addr   = a;
        dataIn = d;
        wrEn   = strb;
        cs     = 1'b1;
        stepCycle();
        cs   = 1'b0;
        wrEn = 4'b0;
    endtask

    task automatic readReg(input logic [11:0] a, output logic [31:0] d);
        addr = a;
        wrEn = 4'b0;
        cs   = 1'b1;
        stepCycle(); // One extra edge lets a previous write settle through the datapath.
        d  = dataOut;
        cs = 1'b0;
    endtask

    task automatic checkReg(input logic [11:0] a, input logic [31:0] expected, input string name);
        logic [31:0] d;
        readReg(a, d);
        checkValue(name, d, expected);
    endtask

    task automatic setGains(input logic [7:0] leadMan, input logic [4:0] leadExp,
                            input logic [7:0] lagMan, input logic [4:0] lagExp);
        writeReg(loopPkg::LF_LEAD_LAG, {leadMan, 3'b0, leadExp, lagMan, 3'b0, lagExp}, 4'hF);
        regLeadMan = leadMan;
        regLeadExp = leadExp;
        regLagMan  = lagMan;
        regLagExp  = lagExp;
    endtask

    task automatic setControl(input logic zero, input logic inv, input logic clear);
        writeReg(loopPkg::LF_CONTROL, {28'b0, clear, 1'b0, inv, zero}, 4'hF);
        regZero  = zero;
        regInv   = inv;
        regClear = clear;
        if (clear) modelAccum = '0;
    endtask

    task automatic setLimit(input logic [31:0] v);
        writeReg(loopPkg::LF_LIMIT, v, 4'hF);
        regLimit = v;
    endtask

    task automatic setLoopData(input logic [31:0] v);
        writeReg(loopPkg::LF_LOOPDATA, v, 4'hF);
        regLoopData = v;
    endtask

    task automatic setLock(input logic [15:0] count, input logic [11:0] threshold);
        writeReg(loopPkg::LF_LOCKDETECTOR, {4'h0, threshold, count}, 4'hF);
    endtask

    function automatic logic [31:0] scaleTerm(input logic signed [15:0] e,
                                              input logic [7:0] man, input logic [4:0] ex);
        longint c;
        longint p;
        c = regZero ? 0 : (regInv ? -longint'(e) : longint'(e));
        p = c * longint'(man);
        p = p >>> ex;
        return p[31:0];
    endfunction

    function automatic logic [31:0] predictOut(input logic [31:0] lead, input logic [31:0] accum);
        longint sum;
        longint lim;
        sum = longint'($signed(lead)) + longint'($signed(accum));
        lim = longint'(regLimit);
        if (sum > lim) sum = lim;
        else if (sum < -lim) sum = -lim;
        return regLoopData + sum[31:0];
    endfunction

    function automatic logic signed [15:0] randomError(input int span);
        int v;
        v = int'($urandom_range(2 * span)) - span;
        return v[15:0];
    endfunction

    // Drives one error sample and queues the value the model predicts for it.
    task automatic sendError(input logic signed [15:0] e);
        logic [31:0] lead;
        lead = scaleTerm(e, regLeadMan, regLeadExp);
        if (regClear) modelAccum = '0;
        else modelAccum = modelAccum + scaleTerm(e, regLagMan, regLagExp);
        expQ.push_back(predictOut(lead, modelAccum));
        sendQ.push_back(cycleCount);
        error       = e;
        errorStrobe = 1'b1;
        stepCycle();
        errorStrobe = 1'b0;
    endtask

    task automatic waitOutputs();
        int n;
        n = 0;
        while (expQ.size() != 0) begin
            if (n == OUT_TIMEOUT) begin
                $display("Timeout: no output strobe arrived within %0d cycles", OUT_TIMEOUT);
                $display("Finished with errors");
                $fatal(1);
            end
            stepCycle();
            n++;
        end
    endtask

    task automatic testRegisters();
        checkReg(loopPkg::LF_CONTROL, 32'h0, "LF_CONTROL after reset");
        checkReg(loopPkg::LF_LEAD_LAG, 32'h0, "LF_LEAD_LAG after reset");
        checkReg(loopPkg::LF_LIMIT, 32'h0, "LF_LIMIT after reset");
        checkReg(loopPkg::LF_LOOPDATA, 32'h0, "LF_LOOPDATA after reset");
        checkReg(loopPkg::LF_LOCKDETECTOR, 32'h0, "LF_LOCKDETECTOR after reset");
        checkReg(loopPkg::LF_INTEGRATOR, 32'h0, "LF_INTEGRATOR after reset");
        writeReg(loopPkg::LF_LIMIT, 32'hA5C3_0F71, 4'hF);
        checkReg(loopPkg::LF_LIMIT, 32'hA5C3_0F71, "LF_LIMIT");
        writeReg(loopPkg::LF_LIMIT, 32'h1122_3344, 4'b0100);
        checkReg(loopPkg::LF_LIMIT, 32'hA522_0F71, "LF_LIMIT byte 2");
        writeReg(loopPkg::LF_LOOPDATA, 32'hDEAD_BEEF, 4'hF);
        writeReg(loopPkg::LF_LOOPDATA, 32'h0000_0055, 4'b0001);
        checkReg(loopPkg::LF_LOOPDATA, 32'hDEAD_BE55, "LF_LOOPDATA byte 0");
        writeReg(loopPkg::LF_LEAD_LAG, 32'hFFFF_FFFF, 4'hF);
        checkReg(loopPkg::LF_LEAD_LAG, 32'hFF1F_FF1F, "LF_LEAD_LAG");
        writeReg(loopPkg::LF_LEAD_LAG, 32'h1234_5678, 4'b1000);
        checkReg(loopPkg::LF_LEAD_LAG, 32'h121F_FF1F, "LF_LEAD_LAG byte 3");
        writeReg(loopPkg::LF_LOCKDETECTOR, 32'hF9A5_C3E1, 4'hF);
        checkReg(loopPkg::LF_LOCKDETECTOR, 32'h09A5_C3E1, "LF_LOCKDETECTOR");
        writeReg(loopPkg::LF_LOCKDETECTOR, 32'h5A00_0000, 4'b1000);
        checkReg(loopPkg::LF_LOCKDETECTOR, 32'h0AA5_C3E1, "LF_LOCKDETECTOR byte 3");
        writeReg(loopPkg::LF_CONTROL, 32'hFFFF_FFFF, 4'hF);
        checkReg(loopPkg::LF_CONTROL, 32'h0000_000B, "LF_CONTROL");
        checkReg(12'h018, 32'h0, "unmapped 0x018");
        checkReg(12'h002, 32'h0, "unmapped 0x002");
        addr = loopPkg::LF_LIMIT;
        cs   = 1'b0;
        stepCycle();
        checkValue("dataOut with cs low", dataOut, 32'h0);
        setControl(1'b0, 1'b0, 1'b0);
        setGains(8'd0, 5'd0, 8'd0, 5'd0);
        setLimit(32'h0);
        setLoopData(32'h0);
        setLock(16'd0, 12'd0);
    endtask

    task automatic testLeadPath();
        setLimit(32'hFFFF_FFFF);
        for (int i = 0; i < 6; i++) begin
            setGains(8'($urandom_range(255)), 5'($urandom_range(10)), 8'd0, 5'd0);
            setLoopData($urandom);
            sendError(randomError(30000));
            waitOutputs();
        end
    endtask

    task automatic testIntegrator();
        setLoopData(32'h0000_1000);
        setGains(8'd3, 5'd1, 8'd17, 5'd2);
        for (int i = 0; i < 8; i++) begin
            sendError(randomError(20000)); // Strobes on consecutive cycles keep three in flight.
        end
        waitOutputs();
        checkReg(loopPkg::LF_INTEGRATOR, modelAccum, "LF_INTEGRATOR");
        setControl(1'b0, 1'b0, 1'b1);
        checkReg(loopPkg::LF_INTEGRATOR, 32'h0, "LF_INTEGRATOR after clear");
        setControl(1'b0, 1'b0, 1'b0);
        sendError(randomError(20000));
        waitOutputs();
    endtask

    task automatic testConditioning();
        setGains(8'd40, 5'd2, 8'd9, 5'd3);
        setControl(1'b0, 1'b1, 1'b0);
        sendError(16'sd1234);
        sendError(-16'sd777);
        waitOutputs();
        setControl(1'b1, 1'b0, 1'b1);
        sendError(randomError(30000));
        waitOutputs();
        checkValue("loopOut with zeroError", lastOut, regLoopData);
        setControl(1'b0, 1'b0, 1'b0);
        setGains(8'd255, 5'd0, 8'd255, 5'd0);
        setLimit(32'd1000);
        setLoopData($urandom);
        sendError(16'sd20000);
        waitOutputs();
        checkValue("loopOut clamped high", lastOut, regLoopData + 32'd1000);
        sendError(-16'sd20000); // The accumulator returns to zero and the lead term lies far below.
        waitOutputs();
        checkValue("loopOut clamped low", lastOut, regLoopData - 32'd1000);
    endtask

    task automatic testLock();
        setGains(8'd5, 5'd1, 8'd2, 5'd4);
        setLimit(32'hFFFF_FFFF);
        setLock(16'd4, 12'd100);
        sendError(16'sd500);
        checkValue("lockStatus", lockStatus, 1'b0);
        for (int i = 0; i < 3; i++) begin
            sendError(randomError(100));
            checkValue("lockStatus before count", lockStatus, 1'b0);
        end
        sendError(randomError(100));
        checkValue("lockStatus at count", lockStatus, 1'b1);
        readReg(loopPkg::LF_CONTROL, rdData);
        checkValue("LF_CONTROL bit 31", rdData[31], 1'b1);
        sendError(-16'sd600);
        checkValue("lockStatus after large error", lockStatus, 1'b0);
        for (int i = 0; i < 3; i++) begin
            sendError(randomError(100));
            checkValue("lockStatus short run", lockStatus, 1'b0);
        end
        waitOutputs();
    endtask

    initial begin
        void'($urandom(32'h0e000ec9));
        rstN        = 1'b0;
        addr        = '0;
        dataIn      = '0;
        cs          = 1'b0;
        wrEn        = 4'b0;
        error       = '0;
        errorStrobe = 1'b0;
        cycleCount  = 0;
        lastOut     = '0;
        {regZero, regInv, regClear} = 3'b0;
        {regLeadMan, regLagMan, regLeadExp, regLagExp} = '0;
        {regLimit, regLoopData, modelAccum} = '0;
        repeat (2) @(posedge clk);
        #2 rstN = 1'b1;
        testRegisters();
        testLeadPath();
        testIntegrator();
        testConditioning();
        testLock();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/loopPkg.sv
verilog/loopCtrlIf.sv
verilog/loopRegs.sv
verilog/errorScaler.sv
verilog/lagIntegrator.sv
verilog/loopCombiner.sv
verilog/lockDetector.sv
verilog/loopFilter.sv
verification/loopFilter_assertions.sv
verification/tbLoopFilter.sv

// ==== Bender.yml ====
package:
  name: loop_filter

sources:
  - verilog/loopPkg.sv
  - verilog/loopCtrlIf.sv
  - verilog/loopRegs.sv
  - verilog/errorScaler.sv
  - verilog/lagIntegrator.sv
  - verilog/loopCombiner.sv
  - verilog/lockDetector.sv
  - verilog/loopFilter.sv
  - target: test
    files:
      - verification/loopFilter_assertions.sv
      - verification/tbLoopFilter.sv
